//--- vlog.f
+incdir+tests
rtl/cad_dims_pkg.sv
rtl/cad_types_pkg.sv
rtl/cad_sequencer.sv
rtl/cad_operand_store.sv
rtl/cad_mac_accum.sv
rtl/cad_max_pool.sv
rtl/cad_bit_serializer.sv
rtl/cad_top.sv
tests/cad_tb.sv

//--- run.sh
#!/bin/sh
# Compile and run the testbench with Verilator, pass only if the pass message shows up
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module cad_tb -o cad_sim
output=$(./obj_dir/cad_sim 2>&1 || true)
echo "$output"
echo "$output" | grep -q "RESULT: PASS"

//--- tests/cad_ref_model.svh
// Reference model on flat row-major arrays; assumes the fixed 8x8 image, 5x5 kernel and 2x2 pooling
`ifndef CAD_REF_MODEL_SVH
`define CAD_REF_MODEL_SVH

// Valid correlation at output position (r, c)
function automatic acc_t ref_corr(input pix_t img_a [IMG_PIXELS], input pix_t ker_a [KER_TAPS],
                                  input int r, input int c);
  int sum;
  sum = 0;
  for (int i = 0; i < KER_DIM; i++)
  begin
    for (int k = 0; k < KER_DIM; k++)
    begin
      sum += int'(img_a[(r + i) * IMG_DIM + c + k]) * int'(ker_a[i * KER_DIM + k]);
    end
  end
  return acc_t'(sum);
endfunction

// Signed maximum over one 2x2 window of the correlation output
function automatic acc_t ref_pool(input pix_t img_a [IMG_PIXELS], input pix_t ker_a [KER_TAPS],
                                  input int wr, input int wc);
  acc_t best;
  acc_t cand;
  best = ref_corr(img_a, ker_a, 2 * wr, 2 * wc);
  for (int p = 1; p < 4; p++)
  begin
    cand = ref_corr(img_a, ker_a, 2 * wr + p / 2, 2 * wc + p % 2);
    if (cand > best)
      best = cand;
  end
  return best;
endfunction

`endif

//--- tests/cad_tb.sv
// Needs a simulator with timing support; jobs run back to back after one reset, no reset between
`default_nettype none
`timescale 1ns/1ps

module cad_tb
  import cad_dims_pkg::*, cad_types_pkg::*;
();

  localparam int NUM_JOBS        = 8;
  localparam int LOAD_LEN        = IMG_PIXELS + KER_TAPS;
  localparam int JOB_WORDS       = POOL_DIM * POOL_DIM;
  localparam int JOB_BITS        = JOB_WORDS * ACC_W;
  localparam int WATCHDOG_CYCLES = NUM_JOBS * 400 + 20;

  typedef enum logic [1:0] {PAT_CONST, PAT_ROW, PAT_COL, PAT_RANDOM} pat_kind_t;

  // Pixel (r, c) is base, base + step * r, base + step * c or random
  typedef struct packed {
    pat_kind_t kind;
    pix_t      base;
    pix_t      step;
  } pattern_t;

  typedef struct packed {
    pattern_t             img;
    pattern_t             ker;
    logic                 use_model;
    acc_t [JOB_WORDS-1:0] expected;
  } job_t;

  logic clk;
  logic rst_n;
  logic in_valid;
  pix_t matrix;
  logic out_valid;
  logic out_value;

  job_t jobs [NUM_JOBS];
  pix_t img [IMG_PIXELS];
  pix_t ker [KER_TAPS];
  acc_t word_q [$];
  acc_t shift_word;
  int   bit_pos    = 0;
  int   bit_total  = 0;
  int   word_total = 0;

  `include "cad_ref_model.svh"

  cad_top cad_top_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .matrix    (matrix),
    .out_valid (out_valid),
    .out_value (out_value)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // --------------------------------------------------
  // Failure handling and compare tasks
  // --------------------------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "%s", why);
  endtask

  task automatic check_pooled(input int job, input int idx, input acc_t got, input acc_t want);
    if (got !== want)
    begin
      $display("ERR job %0d out_value word %0d: got 0x%05h expected 0x%05h", job, idx, got, want);
      abort_run("pooled word mismatch");
    end
  endtask

  task automatic check_bit_count(input int job, input int got, input int want);
    if (got != want)
    begin
      $display("ERR job %0d out_valid bit count: got 0x%0h expected 0x%0h", job, got, want);
      abort_run("wrong number of output bits");
    end
  endtask

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    abort_run("Watchdog expired before all jobs finished");
  end

  // Output collector samples mid-cycle where the outputs are settled
  always @(negedge clk)
  begin
    if (out_valid)
    begin
      shift_word[bit_pos] = out_value;
      bit_total = bit_total + 1;
      if (bit_pos == ACC_W - 1)
      begin
        word_q.push_back(shift_word);
        bit_pos    = 0;
        word_total = word_total + 1;
      end
      else
        bit_pos = bit_pos + 1;
    end
    else if (bit_pos != 0)
      abort_run("out_valid dropped in the middle of a word");
  end

  // --------------------------------------------------
  // Job table helpers and the job runner
  // --------------------------------------------------
  function automatic pattern_t make_pattern(input pat_kind_t kind, input int base, input int step);
    pattern_t p;
    p.kind = kind;
    p.base = pix_t'(base);
    p.step = pix_t'(step);
    return p;
  endfunction

  function automatic job_t make_job(input pattern_t img_p, input pattern_t ker_p,
                                    input logic use_model, input int e0, input int e1,
                                    input int e2, input int e3);
    job_t jb;
    jb.img         = img_p;
    jb.ker         = ker_p;
    jb.use_model   = use_model;
    jb.expected[0] = acc_t'(e0);
    jb.expected[1] = acc_t'(e1);
    jb.expected[2] = acc_t'(e2);
    jb.expected[3] = acc_t'(e3);
    return jb;
  endfunction

  function automatic pix_t pattern_pixel(input pattern_t p, input int r, input int c);
    case (p.kind)
      PAT_ROW:    return pix_t'(int'(p.base) + int'(p.step) * r);
      PAT_COL:    return pix_t'(int'(p.base) + int'(p.step) * c);
      PAT_RANDOM: return pix_t'($urandom);
      default:    return p.base;
    endcase
  endfunction

  task automatic run_job(input int j);
    acc_t want [JOB_WORDS];
    acc_t got;
    for (int r = 0; r < IMG_DIM; r++)
    begin
      for (int c = 0; c < IMG_DIM; c++)
        img[r * IMG_DIM + c] = pattern_pixel(jobs[j].img, r, c);
    end
    for (int r = 0; r < KER_DIM; r++)
    begin
      for (int c = 0; c < KER_DIM; c++)
        ker[r * KER_DIM + c] = pattern_pixel(jobs[j].ker, r, c);
    end
    for (int w = 0; w < JOB_WORDS; w++)
    begin
      if (jobs[j].use_model)
        want[w] = ref_pool(img, ker, w / POOL_DIM, w % POOL_DIM);
      else
        want[w] = jobs[j].expected[w];
    end
    // Image then kernel as one unbroken burst
    for (int i = 0; i < LOAD_LEN; i++)
    begin
      @(negedge clk);
      in_valid = 1'b1;
      matrix   = (i < IMG_PIXELS) ? img[i] : ker[i - IMG_PIXELS];
    end
    @(negedge clk);
    in_valid = 1'b0;
    matrix   = '0;
    wait (word_total >= (j + 1) * JOB_WORDS);
    for (int w = 0; w < JOB_WORDS; w++)
    begin
      got = word_q.pop_front();
      check_pooled(j, w, got, want[w]);
    end
    // Burst must be over one cycle later
    @(negedge clk);
    @(posedge clk);
    check_bit_count(j, bit_total, (j + 1) * JOB_BITS);
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial
  begin
    void'($urandom(32'h20a73990));
    rst_n    = 1'b0;
    in_valid = 1'b0;
    matrix   = '0;
    jobs[0] = make_job(make_pattern(PAT_CONST, 1, 0), make_pattern(PAT_CONST, 1, 0),
                       1'b0, 25, 25, 25, 25);
    jobs[1] = make_job(make_pattern(PAT_CONST, -128, 0), make_pattern(PAT_CONST, 127, 0),
                       1'b0, -406400, -406400, -406400, -406400);
    // Top windows hold only negative samples
    jobs[2] = make_job(make_pattern(PAT_ROW, -40, 10), make_pattern(PAT_CONST, 1, 0),
                       1'b0, -250, -250, 250, 250);
    // Left windows mix -125 and 125
    jobs[3] = make_job(make_pattern(PAT_COL, -25, 10), make_pattern(PAT_CONST, 1, 0),
                       1'b0, 125, 625, 125, 625);
    jobs[4] = make_job(make_pattern(PAT_RANDOM, 0, 0), make_pattern(PAT_RANDOM, 0, 0),
                       1'b1, 0, 0, 0, 0);
    jobs[5] = make_job(make_pattern(PAT_RANDOM, 0, 0), make_pattern(PAT_RANDOM, 0, 0),
                       1'b1, 0, 0, 0, 0);
    jobs[6] = make_job(make_pattern(PAT_CONST, -128, 0), make_pattern(PAT_CONST, -128, 0),
                       1'b0, 409600, 409600, 409600, 409600);
    jobs[7] = make_job(make_pattern(PAT_RANDOM, 0, 0), make_pattern(PAT_CONST, -1, 0),
                       1'b1, 0, 0, 0, 0);
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    // Quiet stretch after reset
    repeat (10) @(negedge clk);
    @(posedge clk);
    check_bit_count(-1, bit_total, 0);
    for (int j = 0; j < NUM_JOBS; j++)
      run_job(j);
    repeat (20) @(negedge clk);
    @(posedge clk);
    check_bit_count(-1, bit_total, NUM_JOBS * JOB_BITS);
    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- rtl/cad_top.sv
// One job at a time; a new load may start once the sequencer is back in idle
`default_nettype none
`timescale 1ns/1ps

module cad_top
  import cad_types_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic in_valid,
  input  pix_t matrix,
  output logic out_valid,
  output logic out_value
);

  logic          wr_img;
  logic          wr_ker;
  load_cnt_t     wr_idx;
  fetch_req_t    fetch;
  row_operands_t operands;
  logic          sample_valid;
  acc_t          sample;
  logic          first_in_window;
  logic          last_in_window;
  logic          pooled_valid;
  acc_t          pooled;

  cad_sequencer sequencer_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .wr_img   (wr_img),
    .wr_ker   (wr_ker),
    .wr_idx   (wr_idx),
    .fetch    (fetch)
  );

  cad_operand_store operand_store_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_img   (wr_img),
    .wr_ker   (wr_ker),
    .wr_idx   (wr_idx),
    .wr_data  (matrix),
    .fetch    (fetch),
    .operands (operands)
  );

  cad_mac_accum mac_accum_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .operands        (operands),
    .sample_valid    (sample_valid),
    .sample          (sample),
    .first_in_window (first_in_window),
    .last_in_window  (last_in_window)
  );

  cad_max_pool max_pool_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .sample_valid    (sample_valid),
    .sample          (sample),
    .first_in_window (first_in_window),
    .last_in_window  (last_in_window),
    .pooled_valid    (pooled_valid),
    .pooled          (pooled)
  );

  cad_bit_serializer bit_serializer_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .pooled_valid (pooled_valid),
    .pooled       (pooled),
    .out_valid    (out_valid),
    .out_value    (out_value)
  );

endmodule

`default_nettype wire

//--- rtl/cad_bit_serializer.sv
// No back-pressure; pushes must be spaced so the two-entry buffer never overflows
`default_nettype none
`timescale 1ns/1ps

module cad_bit_serializer
  import cad_dims_pkg::*, cad_types_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic pooled_valid,
  input  acc_t pooled,
  output logic out_valid,
  output logic out_value
);

  acc_t       word_buf [2];
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] count;
  bit_idx_t   bit_cnt;
  logic       pop;

  // Last bit of the head word goes out this cycle
  assign pop = (count != 2'd0) && (bit_cnt == bit_idx_t'(ACC_W - 1));

  always_ff @(posedge clk)
  begin
    if (pooled_valid)
      word_buf[wr_ptr] <= pooled;
  end

  // --------------------------------------------------
  // Pointers, occupancy and bit position
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr  <= 1'b0;
      rd_ptr  <= 1'b0;
      count   <= 2'd0;
      bit_cnt <= '0;
    end
    else
    begin
      if (pooled_valid)
        wr_ptr <= ~wr_ptr;
      if (pop)
      begin
        rd_ptr  <= ~rd_ptr;
        bit_cnt <= '0;
      end
      else if (count != 2'd0)
        bit_cnt <= bit_cnt + 1'b1;
      count <= count + {1'b0, pooled_valid} - {1'b0, pop};
    end
  end

  // LSB first while a word is held
  assign out_valid = (count != 2'd0);
  assign out_value = out_valid && word_buf[rd_ptr][bit_cnt];

  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    pooled_valid |-> (count != 2'd2));

endmodule

`default_nettype wire

//--- rtl/cad_max_pool.sv
// Window flags are only looked at while sample_valid is high
`default_nettype none
`timescale 1ns/1ps

module cad_max_pool
  import cad_types_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic sample_valid,
  input  acc_t sample,
  input  logic first_in_window,
  input  logic last_in_window,
  output logic pooled_valid,
  output acc_t pooled
);

  acc_t run_max;

  // Signed compare where the first sample of a window always wins
  always_ff @(posedge clk)
  begin
    if (sample_valid)
    begin
      if (first_in_window || (sample > run_max))
        run_max <= sample;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      pooled_valid <= 1'b0;
    else
      pooled_valid <= sample_valid && last_in_window;
  end

  // Already includes the fourth sample when pooled_valid is high
  assign pooled = run_max;

endmodule

`default_nettype wire

//--- rtl/cad_mac_accum.sv
// Sums wrap silently at 20 bits; 8-bit operands over 25 taps never overflow
`default_nettype none
`timescale 1ns/1ps

module cad_mac_accum
  import cad_dims_pkg::*, cad_types_pkg::*;
(
  input  logic          clk,
  input  logic          rst_n,
  input  row_operands_t operands,
  output logic          sample_valid,
  output acc_t          sample,
  output logic          first_in_window,
  output logic          last_in_window
);

  acc_t       row_sum;
  logic       rs_valid;
  fetch_tag_t rs_tag;
  acc_t       rs_sum;
  acc_t       acc;

  // Five signed products of one kernel row
  always_comb
  begin
    row_sum = '0;
    for (int k = 0; k < KER_DIM; k++)
    begin
      row_sum = row_sum + acc_t'(operands.pix[k]) * acc_t'(operands.wgt[k]);
    end
  end

  always_ff @(posedge clk)
  begin
    rs_sum <= row_sum;
    // Restart on the first row, add the rest
    if (rs_valid)
      acc <= rs_tag.first_row ? rs_sum : acc + rs_sum;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rs_valid        <= 1'b0;
      rs_tag          <= '0;
      sample_valid    <= 1'b0;
      first_in_window <= 1'b0;
      last_in_window  <= 1'b0;
    end
    else
    begin
      rs_valid        <= operands.valid;
      rs_tag          <= operands.tag;
      sample_valid    <= rs_valid && rs_tag.last_row;
      first_in_window <= rs_tag.first_in_window;
      last_in_window  <= rs_tag.last_in_window;
    end
  end

  // Holds the full sum in the cycle after the last row
  assign sample = acc;

endmodule

`default_nettype wire

//--- rtl/cad_operand_store.sv
// Requested columns col..col+4 must lie inside the image; no bounds check is done
`default_nettype none
`timescale 1ns/1ps

module cad_operand_store
  import cad_dims_pkg::*, cad_types_pkg::*;
(
  input  logic          clk,
  input  logic          rst_n,
  input  logic          wr_img,
  input  logic          wr_ker,
  input  load_cnt_t     wr_idx,
  input  pix_t          wr_data,
  input  fetch_req_t    fetch,
  output row_operands_t operands
);

  pix_t img_rf [IMG_PIXELS];
  pix_t ker_rf [KER_TAPS];

  logic [IMG_AW-1:0] img_addr [KER_DIM];
  logic [KER_AW-1:0] ker_addr [KER_DIM];

  logic               op_valid;
  fetch_tag_t         op_tag;
  pix_t [KER_DIM-1:0] op_pix;
  pix_t [KER_DIM-1:0] op_wgt;

  // Row-major addresses of the five taps
  always_comb
  begin
    for (int k = 0; k < KER_DIM; k++)
    begin
      img_addr[k] = IMG_AW'(fetch.img_row * IMG_DIM + fetch.img_col + k);
      ker_addr[k] = KER_AW'(fetch.ker_row * KER_DIM + k);
    end
  end

  // --------------------------------------------------
  // Register files and operand read
  // --------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (wr_img)
      img_rf[wr_idx[IMG_AW-1:0]] <= wr_data;
    if (wr_ker)
      ker_rf[wr_idx[KER_AW-1:0]] <= wr_data;
    if (fetch.valid)
    begin
      for (int k = 0; k < KER_DIM; k++)
      begin
        op_pix[k] <= img_rf[img_addr[k]];
        op_wgt[k] <= ker_rf[ker_addr[k]];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      op_valid <= 1'b0;
      op_tag   <= '0;
    end
    else
    begin
      op_valid <= fetch.valid;
      op_tag   <= fetch.tag;
    end
  end

  assign operands = '{valid: op_valid, pix: op_pix, wgt: op_wgt, tag: op_tag};

endmodule

`default_nettype wire

//--- rtl/cad_sequencer.sv
// in_valid must stay high for 89 cycles per job; in_valid during compute is ignored
`default_nettype none
`timescale 1ns/1ps

module cad_sequencer
  import cad_dims_pkg::*, cad_types_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       in_valid,
  output logic       wr_img,
  output logic       wr_ker,
  output load_cnt_t  wr_idx,
  output fetch_req_t fetch
);

  seq_state_t state;
  load_cnt_t  load_cnt;
  coord_t     win_row;
  coord_t     win_col;
  coord_t     pos_row;
  coord_t     pos_col;
  coord_t     ker_row;

  logic ker_last;
  logic pos_col_last;
  logic pos_row_last;
  logic win_col_last;
  logic step_pos_row;
  logic step_win_col;
  logic step_win_row;
  logic job_done;

  // Wrap points of the nested compute counters
  assign ker_last     = (ker_row == coord_t'(KER_DIM - 1));
  assign pos_col_last = (pos_col == coord_t'(CONV_DIM / POOL_DIM - 1));
  assign pos_row_last = (pos_row == coord_t'(CONV_DIM / POOL_DIM - 1));
  assign win_col_last = (win_col == coord_t'(POOL_DIM - 1));
  assign step_pos_row = ker_last && pos_col_last;
  assign step_win_col = step_pos_row && pos_row_last;
  assign step_win_row = step_win_col && win_col_last;
  assign job_done     = step_win_row && (win_row == coord_t'(POOL_DIM - 1));

  // --------------------------------------------------
  // State machine and counters
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= SEQ_IDLE;
      load_cnt <= '0;
      win_row  <= '0;
      win_col  <= '0;
      pos_row  <= '0;
      pos_col  <= '0;
      ker_row  <= '0;
    end
    else
    begin
      case (state)
        SEQ_IDLE:
        begin
          // First pixel is written at index 0 in this cycle
          if (in_valid)
          begin
            load_cnt <= load_cnt_t'(1);
            state    <= SEQ_LOAD_IMG;
          end
        end
        SEQ_LOAD_IMG:
        begin
          if (load_cnt == load_cnt_t'(IMG_PIXELS - 1))
          begin
            load_cnt <= '0;
            state    <= SEQ_LOAD_KER;
          end
          else
            load_cnt <= load_cnt + 1'b1;
        end
        SEQ_LOAD_KER:
        begin
          if (load_cnt == load_cnt_t'(KER_TAPS - 1))
          begin
            load_cnt <= '0;
            state    <= SEQ_COMPUTE;
          end
          else
            load_cnt <= load_cnt + 1'b1;
        end
        SEQ_COMPUTE:
        begin
          ker_row <= ker_last ? '0 : ker_row + 1'b1;
          if (ker_last)
            pos_col <= pos_col_last ? '0 : pos_col + 1'b1;
          if (step_pos_row)
            pos_row <= pos_row_last ? '0 : pos_row + 1'b1;
          if (step_win_col)
            win_col <= win_col_last ? '0 : win_col + 1'b1;
          if (step_win_row)
            win_row <= job_done ? '0 : win_row + 1'b1;
          if (job_done)
            state <= SEQ_IDLE;
        end
        default:
          state <= SEQ_IDLE;
      endcase
    end
  end

  assign wr_img = in_valid && (state == SEQ_IDLE || state == SEQ_LOAD_IMG);
  assign wr_ker = in_valid && (state == SEQ_LOAD_KER);
  assign wr_idx = load_cnt;

  // One kernel row request per compute cycle
  always_comb
  begin
    fetch.valid   = (state == SEQ_COMPUTE);
    fetch.img_row = coord_t'(win_row * (CONV_DIM / POOL_DIM) + pos_row + ker_row);
    fetch.img_col = coord_t'(win_col * (CONV_DIM / POOL_DIM) + pos_col);
    fetch.ker_row = ker_row;
    fetch.tag.first_row       = (ker_row == '0);
    fetch.tag.last_row        = ker_last;
    fetch.tag.last_in_window  = pos_row_last && pos_col_last;
    fetch.tag.first_in_window = (pos_row == '0) && (pos_col == '0);
  end

  // Image and kernel must arrive as one unbroken burst
  a_load_burst: assert property (@(posedge clk) disable iff (!rst_n)
    (state == SEQ_LOAD_IMG || state == SEQ_LOAD_KER) |-> in_valid);

endmodule

`default_nettype wire

//--- rtl/cad_types_pkg.sv
// Coordinates are 3 bits wide, enough for the 8x8 image only
`default_nettype none

package cad_types_pkg;

  import cad_dims_pkg::*;

  typedef logic signed [PIX_W-1:0] pix_t;
  typedef logic signed [ACC_W-1:0] acc_t;
  typedef logic [2:0]              coord_t;
  typedef logic [6:0]              load_cnt_t;
  typedef logic [4:0]              bit_idx_t;

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_LOAD_IMG,
    SEQ_LOAD_KER,
    SEQ_COMPUTE
  } seq_state_t;

  // Flags that ride along the pipeline with each kernel row
  typedef struct packed {
    logic first_row;
    logic last_row;
    logic last_in_window;
    logic first_in_window;
  } fetch_tag_t;

  typedef struct packed {
    logic       valid;
    coord_t     img_row;
    coord_t     img_col;
    coord_t     ker_row;
    fetch_tag_t tag;
  } fetch_req_t;

  // One image row segment and the matching kernel row
  typedef struct packed {
    logic                    valid;
    pix_t [KER_DIM-1:0]      pix;
    pix_t [KER_DIM-1:0]      wgt;
    fetch_tag_t              tag;
  } row_operands_t;

endpackage

`default_nettype wire

//--- rtl/cad_dims_pkg.sv
// Fixed 8x8 image and 5x5 kernel only; no other sizes are supported
`default_nettype none

package cad_dims_pkg;

  // --------------------------------------------------
  // Geometry
  // --------------------------------------------------
  localparam int IMG_DIM  = 8;
  localparam int KER_DIM  = 5;
  localparam int CONV_DIM = IMG_DIM - KER_DIM + 1;
  localparam int POOL_DIM = CONV_DIM / 2;

  // Data widths
  localparam int PIX_W = 8;
  localparam int ACC_W = 20;

  // Load lengths and register file address widths
  localparam int IMG_PIXELS = IMG_DIM * IMG_DIM;
  localparam int KER_TAPS   = KER_DIM * KER_DIM;
  localparam int IMG_AW     = $clog2(IMG_PIXELS);
  localparam int KER_AW     = $clog2(KER_TAPS);

endpackage

`default_nettype wire
